//--- Makefile
SRCS := $(wildcard hw/*.sv hw/*.svh tests/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vservlet_tb: servlet.f $(SRCS)
	verilator --binary --timing --assert -f servlet.f --top-module servlet_tb -o Vservlet_tb

run: obj_dir/Vservlet_tb
	@out="$$(./obj_dir/Vservlet_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

//--- hw/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
   // Instruction master
   input  servlet_pkg::word_t i_ibus_adr,
   input  logic               i_ibus_cyc,
   output servlet_pkg::word_t o_ibus_rdt,
   output logic               o_ibus_ack,
   // Data master
   input  servlet_pkg::word_t i_dbus_adr,
   input  servlet_pkg::word_t i_dbus_dat,
   input  servlet_pkg::sel_t  i_dbus_sel,
   input  logic               i_dbus_we,
   input  logic               i_dbus_cyc,
   output servlet_pkg::word_t o_dbus_rdt,
   output logic               o_dbus_ack,
   // Merged master
   output servlet_pkg::word_t o_cpu_adr,
   output servlet_pkg::word_t o_cpu_dat,
   output servlet_pkg::sel_t  o_cpu_sel,
   output logic               o_cpu_we,
   output logic               o_cpu_cyc,
   input  servlet_pkg::word_t i_cpu_rdt,
   input  logic               i_cpu_ack
);

   // Instruction fetch owns the bus whenever it asks for it
   assign o_cpu_adr = i_ibus_cyc ? i_ibus_adr : i_dbus_adr;
   assign o_cpu_dat = i_dbus_dat;
   // Fetches are always full-word reads
   assign o_cpu_sel = i_ibus_cyc ? '1 : i_dbus_sel;
   assign o_cpu_we  = i_dbus_we & ~i_ibus_cyc;
   assign o_cpu_cyc = i_ibus_cyc | i_dbus_cyc;

   // Read data is shared, ack goes to the master in front
   assign o_ibus_rdt = i_cpu_rdt;
   assign o_dbus_rdt = i_cpu_rdt;
   assign o_ibus_ack = i_cpu_ack & i_ibus_cyc;
   assign o_dbus_ack = i_cpu_ack & ~i_ibus_cyc;

endmodule

//--- hw/bus_decoder.sv
`timescale 1ns/1ps
`include "servlet_settings.svh"

module bus_decoder (
   input  logic               i_clk,
   input  logic               i_rst,
   // Merged master
   input  servlet_pkg::word_t i_cpu_adr,
   input  servlet_pkg::word_t i_cpu_dat,
   input  servlet_pkg::sel_t  i_cpu_sel,
   input  logic               i_cpu_we,
   input  logic               i_cpu_cyc,
   output servlet_pkg::word_t o_cpu_rdt,
   output logic               o_cpu_ack,
   // RAM
   output servlet_pkg::word_t o_mem_adr,
   output servlet_pkg::word_t o_mem_dat,
   output servlet_pkg::sel_t  o_mem_sel,
   output logic               o_mem_we,
   output logic               o_mem_cyc,
   input  servlet_pkg::word_t i_mem_rdt,
   // Timer
   output servlet_pkg::word_t o_timer_dat,
   output logic               o_timer_we,
   output logic               o_timer_cyc,
   input  servlet_pkg::word_t i_timer_rdt,
   // GPIO pin
   output logic               o_gpio
);

   import servlet_pkg::*;

   bus_target_e tgt;
   logic        gpio_cyc;

   // ******************************************************************
   // Address decode
   // ******************************************************************

   assign tgt = bus_target_e'(i_cpu_adr[`SERVLET_REGION_HI:`SERVLET_REGION_LO]);

   assign o_mem_adr   = i_cpu_adr;
   assign o_mem_dat   = i_cpu_dat;
   assign o_mem_sel   = i_cpu_sel;
   assign o_mem_we    = i_cpu_we;
   assign o_mem_cyc   = i_cpu_cyc & (tgt == TGT_MEM);

   assign o_timer_dat = i_cpu_dat;
   assign o_timer_we  = i_cpu_we;
   assign o_timer_cyc = i_cpu_cyc & (tgt == TGT_TIMER);

   assign gpio_cyc    = i_cpu_cyc & (tgt == TGT_GPIO);

   // Unmapped region reads as zero
   always_comb begin
      case (tgt)
         TGT_MEM:   o_cpu_rdt = i_mem_rdt;
         TGT_GPIO:  o_cpu_rdt = {31'd0, o_gpio};
         TGT_TIMER: o_cpu_rdt = i_timer_rdt;
         default:   o_cpu_rdt = '0;
      endcase
   end

   // ******************************************************************
   // Ack and GPIO latch
   // ******************************************************************

   // A held cyc gets acked every other cycle
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_cpu_ack <= 1'b0;
      end else begin
         o_cpu_ack <= i_cpu_cyc & ~o_cpu_ack;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_gpio <= 1'b0;
      end else if (gpio_cyc && i_cpu_we) begin
         o_gpio <= i_cpu_dat[0];
      end
   end

   a_ack_single_cycle: assert property (
      @(posedge i_clk) disable iff (i_rst)
      o_cpu_ack |=> !o_cpu_ack
   );

   a_one_slave_cyc: assert property (
      @(posedge i_clk) disable iff (i_rst)
      $onehot0({o_mem_cyc, o_timer_cyc, gpio_cyc})
   );

endmodule

//--- hw/mtimer.sv
`timescale 1ns/1ps

module mtimer (
   input  logic               i_clk,
   input  logic               i_rst,
   input  logic               i_cyc,
   input  logic               i_we,
   input  servlet_pkg::word_t i_dat,
   output servlet_pkg::word_t o_rdt,
   output logic               o_irq
);

   import servlet_pkg::*;

   word_t mtime;
   word_t mtimecmp;

   // ******************************************************************
   // Counter and compare
   // ******************************************************************

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         mtime <= '0;
      end else begin
         mtime <= mtime + 32'd1;
      end
   end

   // Starts at the top so nothing fires out of reset
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         mtimecmp <= '1;
      end else if (i_cyc && i_we) begin
         mtimecmp <= i_dat;
      end
   end

   assign o_rdt = mtime;

   // Level irq while mtime is at or past the unsigned compare value
   assign o_irq = (mtime >= mtimecmp);

   a_mtime_step: assert property (
      @(posedge i_clk)
      !i_rst |=> (mtime == $past(mtime) + 32'd1)
   );

endmodule

//--- hw/servlet_pkg.sv
package servlet_pkg;

   // Bus data and byte address
   typedef logic [31:0] word_t;

   // One enable per byte lane of a word
   typedef logic [3:0] sel_t;

   // Encoding follows the region bits of the address
   typedef enum logic [1:0] {
      TGT_MEM   = 2'b00,
      TGT_GPIO  = 2'b01,
      TGT_TIMER = 2'b10,
      TGT_NONE  = 2'b11
   } bus_target_e;

endpackage

//--- hw/servlet_settings.svh
`ifndef SERVLET_SETTINGS_SVH
`define SERVLET_SETTINGS_SVH

// RAM size in 32-bit words
`define SERVLET_MEM_DEPTH 2048

// Address bits that pick the target region
// 00 memory, 01 GPIO, 10 timer, 11 unmapped
`define SERVLET_REGION_HI 31
`define SERVLET_REGION_LO 30

`endif

//--- hw/servlet_top.sv
`timescale 1ns/1ps
`include "servlet_settings.svh"

module servlet_top (
   input  logic               wb_clk,
   input  logic               i_rst,
   // Instruction master port
   input  servlet_pkg::word_t i_ibus_adr,
   input  logic               i_ibus_cyc,
   output servlet_pkg::word_t o_ibus_rdt,
   output logic               o_ibus_ack,
   // Data master port
   input  servlet_pkg::word_t i_dbus_adr,
   input  servlet_pkg::word_t i_dbus_dat,
   input  servlet_pkg::sel_t  i_dbus_sel,
   input  logic               i_dbus_we,
   input  logic               i_dbus_cyc,
   output servlet_pkg::word_t o_dbus_rdt,
   output logic               o_dbus_ack,
   output logic               o_timer_irq,
   output logic               o_gpio
);

   import servlet_pkg::*;

   localparam int mem_aw = $clog2(`SERVLET_MEM_DEPTH);

   word_t cpu_adr;
   word_t cpu_dat;
   sel_t  cpu_sel;
   logic  cpu_we;
   logic  cpu_cyc;
   word_t cpu_rdt;
   logic  cpu_ack;

   word_t mem_adr;
   word_t mem_dat;
   sel_t  mem_sel;
   logic  mem_we;
   logic  mem_cyc;
   word_t mem_rdt;

   word_t timer_dat;
   logic  timer_we;
   logic  timer_cyc;
   word_t timer_rdt;

   bus_arbiter bus_arbiter (
      .i_ibus_adr (i_ibus_adr),
      .i_ibus_cyc (i_ibus_cyc),
      .o_ibus_rdt (o_ibus_rdt),
      .o_ibus_ack (o_ibus_ack),
      .i_dbus_adr (i_dbus_adr),
      .i_dbus_dat (i_dbus_dat),
      .i_dbus_sel (i_dbus_sel),
      .i_dbus_we  (i_dbus_we),
      .i_dbus_cyc (i_dbus_cyc),
      .o_dbus_rdt (o_dbus_rdt),
      .o_dbus_ack (o_dbus_ack),
      .o_cpu_adr  (cpu_adr),
      .o_cpu_dat  (cpu_dat),
      .o_cpu_sel  (cpu_sel),
      .o_cpu_we   (cpu_we),
      .o_cpu_cyc  (cpu_cyc),
      .i_cpu_rdt  (cpu_rdt),
      .i_cpu_ack  (cpu_ack)
   );

   bus_decoder bus_decoder (
      .i_clk       (wb_clk),
      .i_rst       (i_rst),
      .i_cpu_adr   (cpu_adr),
      .i_cpu_dat   (cpu_dat),
      .i_cpu_sel   (cpu_sel),
      .i_cpu_we    (cpu_we),
      .i_cpu_cyc   (cpu_cyc),
      .o_cpu_rdt   (cpu_rdt),
      .o_cpu_ack   (cpu_ack),
      .o_mem_adr   (mem_adr),
      .o_mem_dat   (mem_dat),
      .o_mem_sel   (mem_sel),
      .o_mem_we    (mem_we),
      .o_mem_cyc   (mem_cyc),
      .i_mem_rdt   (mem_rdt),
      .o_timer_dat (timer_dat),
      .o_timer_we  (timer_we),
      .o_timer_cyc (timer_cyc),
      .i_timer_rdt (timer_rdt),
      .o_gpio      (o_gpio)
   );

   // Byte address in, word index to the array
   wb_ram #(
      .depth (`SERVLET_MEM_DEPTH)
   ) ram (
      .i_clk (wb_clk),
      .i_adr (mem_adr[mem_aw+1:2]),
      .i_cyc (mem_cyc),
      .i_we  (mem_we),
      .i_sel (mem_sel),
      .i_dat (mem_dat),
      .o_rdt (mem_rdt)
   );

   mtimer mtimer (
      .i_clk (wb_clk),
      .i_rst (i_rst),
      .i_cyc (timer_cyc),
      .i_we  (timer_we),
      .i_dat (timer_dat),
      .o_rdt (timer_rdt),
      .o_irq (o_timer_irq)
   );

endmodule

//--- hw/wb_ram.sv
`timescale 1ns/1ps
`include "servlet_settings.svh"

module wb_ram #(
   parameter int depth = `SERVLET_MEM_DEPTH
) (
   input  logic                     i_clk,
   input  logic [$clog2(depth)-1:0] i_adr,
   input  logic                     i_cyc,
   input  logic                     i_we,
   input  servlet_pkg::sel_t        i_sel,
   input  servlet_pkg::word_t       i_dat,
   output servlet_pkg::word_t       o_rdt
);

   import servlet_pkg::*;

   localparam int lanes = $bits(sel_t);

   word_t mem [depth];

   // Byte-lane writes
   always_ff @(posedge i_clk) begin
      if (i_cyc && i_we) begin
         for (int i = 0; i < lanes; i++) begin
            if (i_sel[i]) begin
               mem[i_adr][i*8 +: 8] <= i_dat[i*8 +: 8];
            end
         end
      end
   end

   // Read lands in the ack cycle
   always_ff @(posedge i_clk) begin
      if (i_cyc) begin
         o_rdt <= mem[i_adr];
      end
   end

   a_write_has_lanes: assert property (
      @(posedge i_clk)
      (i_cyc && i_we) |-> (i_sel != '0)
   );

endmodule

//--- servlet.f
+incdir+hw
hw/servlet_pkg.sv
hw/bus_arbiter.sv
hw/bus_decoder.sv
hw/wb_ram.sv
hw/mtimer.sv
hw/servlet_top.sv
tests/servlet_tb.sv

//--- tests/servlet_tb.sv
`timescale 1ns/1ps
`include "servlet_settings.svh"

module servlet_tb;

   import servlet_pkg::*;

   localparam int clk_period = 100;
   localparam int num_tests  = 6;
   localparam int xfer_limit = 20;
   localparam int mem_words  = `SERVLET_MEM_DEPTH;
   localparam int irq_lead   = 20;

   logic  wb_clk;
   logic  i_rst;
   word_t i_ibus_adr;
   logic  i_ibus_cyc;
   word_t o_ibus_rdt;
   logic  o_ibus_ack;
   word_t i_dbus_adr;
   word_t i_dbus_dat;
   sel_t  i_dbus_sel;
   logic  i_dbus_we;
   logic  i_dbus_cyc;
   word_t o_dbus_rdt;
   logic  o_dbus_ack;
   logic  o_timer_irq;
   logic  o_gpio;

   word_t model [mem_words];
   int    written [$];
   int    checks;
   int    errors;
   int    failed_tests;
   int    test_errors;
   int    last_wait;

   servlet_top dut (
      .wb_clk      (wb_clk),
      .i_rst       (i_rst),
      .i_ibus_adr  (i_ibus_adr),
      .i_ibus_cyc  (i_ibus_cyc),
      .o_ibus_rdt  (o_ibus_rdt),
      .o_ibus_ack  (o_ibus_ack),
      .i_dbus_adr  (i_dbus_adr),
      .i_dbus_dat  (i_dbus_dat),
      .i_dbus_sel  (i_dbus_sel),
      .i_dbus_we   (i_dbus_we),
      .i_dbus_cyc  (i_dbus_cyc),
      .o_dbus_rdt  (o_dbus_rdt),
      .o_dbus_ack  (o_dbus_ack),
      .o_timer_irq (o_timer_irq),
      .o_gpio      (o_gpio)
   );

   always #(clk_period / 2) wb_clk = ~wb_clk;

   initial begin
      #(num_tests * 2000 * clk_period);
      $display("Watchdog expired before all tests finished");
      $display("*** TEST FAILED ***");
      $finish;
   end

   // *********************************************************************
   // Helpers
   // *********************************************************************

   function automatic word_t region_adr(input logic [1:0] region);
      return word_t'(region) << `SERVLET_REGION_LO;
   endfunction

   // Word index to byte address in region 00
   function automatic word_t mem_adr(input int idx);
      return word_t'(idx) << 2;
   endfunction

   function automatic word_t merge_lanes(input word_t old, input word_t dat, input sel_t sel);
      word_t res;
      res = old;
      for (int l = 0; l < 4; l++) begin
         if (sel[l]) begin
            res[l*8 +: 8] = dat[l*8 +: 8];
         end
      end
      return res;
   endfunction

   task automatic check_word(input string name, input word_t exp, input word_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
      end
   endtask

   task automatic finish_test(input string name);
      if (errors != test_errors) begin
         failed_tests++;
         $display("test %s: failed with %0d errors", name, errors - test_errors);
      end else begin
         $display("test %s: passed", name);
      end
      test_errors = errors;
   endtask

   // Sample at the falling edge, where ack and read data are settled
   task automatic wait_for_ack(input logic use_ibus, input string what, output word_t rdt);
      int   n;
      logic ack;
      n   = 0;
      ack = 1'b0;
      rdt = '0;
      while (!ack && n < xfer_limit) begin
         @(negedge wb_clk);
         n++;
         ack = use_ibus ? o_ibus_ack : o_dbus_ack;
      end
      if (ack) begin
         rdt = use_ibus ? o_ibus_rdt : o_dbus_rdt;
      end else begin
         errors++;
         $display("%s at %0t got no ack within %0d cycles", what, $time, xfer_limit);
      end
      last_wait = n - 1;
   endtask

   // *********************************************************************
   // Bus master tasks
   // *********************************************************************

   task automatic dbus_write(input word_t adr, input word_t dat, input sel_t sel);
      word_t ignored;
      @(posedge wb_clk);
      #1;
      i_dbus_adr = adr;
      i_dbus_dat = dat;
      i_dbus_sel = sel;
      i_dbus_we  = 1'b1;
      i_dbus_cyc = 1'b1;
      wait_for_ack(1'b0, "dbus write", ignored);
      @(posedge wb_clk);
      #1;
      i_dbus_cyc = 1'b0;
      i_dbus_we  = 1'b0;
   endtask

   task automatic dbus_read(input word_t adr, output word_t rdt);
      @(posedge wb_clk);
      #1;
      i_dbus_adr = adr;
      i_dbus_sel = 4'hf;
      i_dbus_we  = 1'b0;
      i_dbus_cyc = 1'b1;
      wait_for_ack(1'b0, "dbus read", rdt);
      @(posedge wb_clk);
      #1;
      i_dbus_cyc = 1'b0;
   endtask

   task automatic ibus_read(input word_t adr, output word_t rdt);
      @(posedge wb_clk);
      #1;
      i_ibus_adr = adr;
      i_ibus_cyc = 1'b1;
      wait_for_ack(1'b1, "ibus read", rdt);
      @(posedge wb_clk);
      #1;
      i_ibus_cyc = 1'b0;
   endtask

   // *********************************************************************
   // Tests
   // *********************************************************************

   task automatic test_reset_state();
      @(negedge wb_clk);
      check_bit("o_ibus_ack", 1'b0, o_ibus_ack);
      check_bit("o_dbus_ack", 1'b0, o_dbus_ack);
      check_bit("o_gpio", 1'b0, o_gpio);
      check_bit("o_timer_irq", 1'b0, o_timer_irq);
      finish_test("reset_state");
   endtask

   task automatic test_ram_lanes();
      int    idx;
      int    lane;
      word_t dat;
      word_t rdt;
      sel_t  sel;
      for (int i = 0; i < 12; i++) begin
         idx = $urandom_range(mem_words - 1, 0);
         dat = $urandom();
         dbus_write(mem_adr(idx), dat, 4'hf);
         check_word("dbus write latency", 32'd1, word_t'(last_wait));
         model[idx] = dat;
         written.push_back(idx);
      end
      // Single-lane overwrites
      for (int i = 0; i < 8; i++) begin
         idx  = written[$urandom_range(written.size() - 1, 0)];
         lane = $urandom_range(3, 0);
         sel  = sel_t'(1 << lane);
         dat  = $urandom();
         dbus_write(mem_adr(idx), dat, sel);
         check_word("dbus lane write latency", 32'd1, word_t'(last_wait));
         model[idx] = merge_lanes(model[idx], dat, sel);
      end
      foreach (written[i]) begin
         dbus_read(mem_adr(written[i]), rdt);
         check_word("o_dbus_rdt", model[written[i]], rdt);
         check_word("dbus read latency", 32'd1, word_t'(last_wait));
      end
      finish_test("ram_lanes");
   endtask

   task automatic test_ifetch();
      word_t rdt;
      foreach (written[i]) begin
         ibus_read(mem_adr(written[i]), rdt);
         check_word("o_ibus_rdt", model[written[i]], rdt);
         check_word("ibus read latency", 32'd1, word_t'(last_wait));
      end
      finish_test("ifetch");
   endtask

   task automatic test_arbitration();
      int    a;
      int    b;
      logic  early;
      logic  got;
      word_t rdt;
      a     = written[0];
      b     = written[1];
      early = 1'b0;
      got   = 1'b0;
      @(posedge wb_clk);
      #1;
      i_ibus_adr = mem_adr(a);
      i_ibus_cyc = 1'b1;
      i_dbus_adr = mem_adr(b);
      i_dbus_sel = 4'hf;
      i_dbus_we  = 1'b0;
      i_dbus_cyc = 1'b1;
      for (int n = 0; n < xfer_limit && !got; n++) begin
         @(negedge wb_clk);
         if (o_dbus_ack) begin
            early = 1'b1;
         end
         if (o_ibus_ack) begin
            got = 1'b1;
            check_word("o_ibus_rdt", model[a], o_ibus_rdt);
         end
      end
      if (!got) begin
         errors++;
         $display("ibus fetch at %0t got no ack while dbus was waiting", $time);
      end
      check_bit("o_dbus_ack while ibus holds the bus", 1'b0, early);
      @(posedge wb_clk);
      #1;
      i_ibus_cyc = 1'b0;
      wait_for_ack(1'b0, "dbus read behind ibus", rdt);
      check_word("o_dbus_rdt", model[b], rdt);
      @(posedge wb_clk);
      #1;
      i_dbus_cyc = 1'b0;
      finish_test("arbitration");
   endtask

   task automatic test_gpio();
      word_t rdt;
      dbus_write(region_adr(2'b01), 32'h0000_0001, 4'hf);
      check_bit("o_gpio", 1'b1, o_gpio);
      dbus_read(region_adr(2'b01), rdt);
      check_word("o_dbus_rdt", 32'd1, rdt);
      dbus_write(region_adr(2'b01), 32'hffff_fffe, 4'hf);
      check_bit("o_gpio", 1'b0, o_gpio);
      dbus_read(region_adr(2'b01), rdt);
      check_word("o_dbus_rdt", 32'd0, rdt);
      // Unmapped region
      dbus_read(region_adr(2'b11) | 32'h0000_0100, rdt);
      check_word("o_dbus_rdt", 32'd0, rdt);
      check_word("unmapped ack latency", 32'd1, word_t'(last_wait));
      finish_test("gpio");
   endtask

   task automatic test_timer();
      word_t t1;
      word_t t2;
      logic  stray;
      int    n;
      dbus_read(region_adr(2'b10), t1);
      dbus_read(region_adr(2'b10), t2);
      check_bit("mtime increasing", 1'b1, t2 > t1);
      dbus_write(region_adr(2'b10), t2 + 32'h0010_0000, 4'hf);
      stray = 1'b0;
      repeat (50) begin
         @(negedge wb_clk);
         if (o_timer_irq) begin
            stray = 1'b1;
         end
      end
      check_bit("o_timer_irq far compare", 1'b0, stray);
      dbus_read(region_adr(2'b10), t1);
      dbus_write(region_adr(2'b10), t1 + irq_lead, 4'hf);
      n = 0;
      while (!o_timer_irq && n < irq_lead + 10) begin
         @(negedge wb_clk);
         n++;
      end
      check_bit("o_timer_irq", 1'b1, o_timer_irq);
      stray = 1'b0;
      repeat (10) begin
         @(negedge wb_clk);
         if (!o_timer_irq) begin
            stray = 1'b1;
         end
      end
      check_bit("o_timer_irq dropped", 1'b0, stray);
      dbus_write(region_adr(2'b10), 32'hffff_ffff, 4'hf);
      @(negedge wb_clk);
      check_bit("o_timer_irq", 1'b0, o_timer_irq);
      finish_test("timer");
   endtask

   initial begin
      wb_clk       = 1'b0;
      i_rst        = 1'b1;
      i_ibus_adr   = '0;
      i_ibus_cyc   = 1'b0;
      i_dbus_adr   = '0;
      i_dbus_dat   = '0;
      i_dbus_sel   = '0;
      i_dbus_we    = 1'b0;
      i_dbus_cyc   = 1'b0;
      checks       = 0;
      errors       = 0;
      failed_tests = 0;
      test_errors  = 0;
      last_wait    = 0;
      void'($urandom(32'h5de6_fd1d));
      repeat (3) @(posedge wb_clk);
      #1;
      i_rst = 1'b0;
      test_reset_state();
      test_ram_lanes();
      test_ifetch();
      test_arbitration();
      test_gpio();
      test_timer();
      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               num_tests, failed_tests, checks, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule
